/* verilog.f */
+incdir+logic
logic/rv_pkg.sv
logic/issue_if.sv
logic/wb_if.sv
logic/fetch_ctrl.sv
logic/pc_counter.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/gpr_file.sv
logic/rv_pipeline.sv
tests/rv_pipeline_properties.sv
tests/rv_pipeline_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := rv_pipeline_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
SIM_LOG   := sim.log
PASS_MSG  := === PASS ===

SOURCES   := $(shell grep -v '^+' $(FILELIST)) logic/rv_macros.svh
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -qF -- '$(PASS_MSG)' $(SIM_LOG) || { echo "Simulation failed"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)

/* tests/rv_pipeline_tb.sv */
// Testbench for the rv_pipeline core. A memory model serves a fixed program
// with random grant and receive delays. An architectural model checks every
// retired instruction. Protocol checks come from the bound properties module.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_pipeline_tb;

    localparam logic [31:0] NOP_WORD   = 32'h0000_0013;      // addi x0, x0, 0
    localparam int          LAST_IDX   = 24;                 // Final program word
    localparam logic [31:0] LAST_PC    = `RV_PC_RESET + 32'(LAST_IDX * 4);
    localparam int          IDLE_LIMIT = 64;                 // Cycles with no retire

    logic                  g_clk = 1'b0;
    logic                  reset;
    logic                  imem_gnt;
    logic                  imem_recv;
    logic [31:0]           imem_rdata;
    logic                  imem_req;
    logic [`RV_XLEN-1:0]   imem_addr;
    logic                  trs_valid;
    logic [`RV_XLEN-1:0]   trs_pc;
    logic [31:0]           trs_instr;
    logic                  trs_wen;
    logic [`RV_REG_AW-1:0] trs_rd;
    logic [`RV_XLEN-1:0]   trs_wdata;

    logic [31:0] prog     [0:31] = '{default: NOP_WORD};    // Word 0 at reset PC
    logic [31:0] ref_regs [0:31] = '{default: 32'd0};       // Reference registers
    logic [31:0] exp_pc    = `RV_PC_RESET;                   // Expected next retire
    int          retired   = 0;
    logic        last_seen = 1'b0;
    logic [4:0]  load_idx  = 5'd0;
    logic [15:0] lfsr      = 16'd95;
    logic        mem_busy  = 1'b0;                           // Granted, not answered
    logic [1:0]  gnt_wait  = 2'd0;
    logic [1:0]  recv_wait = 2'd0;
    logic [31:0] gnt_addr  = 32'd0;

    always #50 g_clk = ~g_clk;

    rv_pipeline dut_i (
        .g_clk     (g_clk),     .reset      (reset),
        .imem_gnt  (imem_gnt),  .imem_recv  (imem_recv),
        .imem_rdata(imem_rdata),.imem_req   (imem_req),
        .imem_addr (imem_addr), .trs_valid  (trs_valid),
        .trs_pc    (trs_pc),    .trs_instr  (trs_instr),
        .trs_wen   (trs_wen),   .trs_rd     (trs_rd),
        .trs_wdata (trs_wdata)
    );

    // ------------------------------
    // Helpers
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois, maximal length
    endfunction

    task automatic draw_delay(output logic [1:0] v);
        for (int i = 0; i < 2; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);                      // One step per bit
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `RV_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic logic [31:0] prog_word(input logic [31:0] addr);
        logic [31:0] offs;
        offs = (addr - `RV_PC_RESET) >> 2;
        if (offs < 32'd32) return prog[offs[4:0]];
        return NOP_WORD;                                 // Past the array
    endfunction

    task automatic put(input logic [31:0] word);
        prog[load_idx] = word;
        load_idx = load_idx + 5'd1;
    endtask

    task automatic load_program();
        put(enc_i(12'd5, 5'd0, `RV_F3_ADD, 5'd1));               // x1 = 5
        put(enc_i(12'd3, 5'd1, `RV_F3_ADD, 5'd2));               // x1 at distance 1
        put(enc_r(7'd0, 5'd2, 5'd1, `RV_F3_ADD, 5'd3));          // Distances 1 and 2
        put(enc_r(`RV_F7_SUB, 5'd1, 5'd3, `RV_F3_ADD, 5'd4));    // x1 at distance 3
        put(enc_r(7'd0, 5'd2, 5'd4, `RV_F3_XOR, 5'd5));
        put(enc_i(12'h0f0, 5'd3, `RV_F3_OR, 5'd6));
        put(enc_i(12'hfff, 5'd6, `RV_F3_AND, 5'd7));             // Immediate -1
        put(enc_i(12'h800, 5'd7, `RV_F3_XOR, 5'd8));             // Most negative imm
        put(enc_r(7'd0, 5'd3, 5'd8, `RV_F3_OR, 5'd9));
        put(enc_r(7'd0, 5'd6, 5'd9, `RV_F3_AND, 5'd10));
        put(enc_r(`RV_F7_SUB, 5'd10, 5'd2, `RV_F3_ADD, 5'd11));
        put(enc_i(12'd7, 5'd1, `RV_F3_ADD, 5'd0));               // rd is x0
        put(enc_r(7'd0, 5'd1, 5'd0, `RV_F3_ADD, 5'd12));         // Reads x0
        put(enc_i(12'd1, 5'd1, 3'b001, 5'd13));                  // SLLI, unsupported
        put(32'h0000_0073);                                      // ECALL, unsupported
        put(enc_r(7'd0, 5'd12, 5'd13, `RV_F3_ADD, 5'd14));       // x13 still zero
        put(enc_jal(21'd8, 5'd15));                              // Skips one word
        put(enc_i(12'd99, 5'd0, `RV_F3_ADD, 5'd16));             // Never retires
        put(enc_i(12'd1, 5'd15, `RV_F3_ADD, 5'd17));             // Uses link value
        put(enc_jal(21'd8, 5'd0));                               // Jump, no link
        put(enc_i(12'd77, 5'd0, `RV_F3_ADD, 5'd18));             // Never retires
        put(enc_r(7'd0, 5'd11, 5'd17, `RV_F3_ADD, 5'd19));
        put(enc_r(`RV_F7_SUB, 5'd19, 5'd0, `RV_F3_ADD, 5'd20));
        put(enc_r(7'd0, 5'd19, 5'd20, `RV_F3_XOR, 5'd21));
        put(enc_r(7'd0, 5'd20, 5'd21, `RV_F3_AND, 5'd22));       // LAST_IDX
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        abort_run($sformatf("FAIL time=%0t %s got=0x%08h expected=0x%08h",
                            $time, name, got, exp));
    endtask

    // ------------------------------
    // Architectural model, one call per retired instruction
    task automatic check_retire();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic [4:0]  rd;
        logic        writes;
        w       = prog_word(exp_pc);
        rd      = w[11:7];
        a       = ref_regs[w[19:15]];
        b       = (w[6:0] == `RV_OP_IMM) ? {{20{w[31]}}, w[31:20]} : ref_regs[w[24:20]];
        result  = 32'd0;
        writes  = 1'b0;
        next_pc = exp_pc + `RV_PC_STEP;
        if (w[6:0] == `RV_OP_JAL) begin
            writes  = 1'b1;
            result  = exp_pc + `RV_PC_STEP;                  // Link address
            next_pc = exp_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end else if (w[6:0] == `RV_OP_IMM || (w[6:0] == `RV_OP_REG && w[31:25] == 7'd0)) begin
            writes = 1'b1;
            case (w[14:12])
                `RV_F3_ADD: result = a + b;
                `RV_F3_XOR: result = a ^ b;
                `RV_F3_OR:  result = a | b;
                `RV_F3_AND: result = a & b;
                default:    writes = 1'b0;                   // Not in the subset
            endcase
        end else if (w[6:0] == `RV_OP_REG && w[31:25] == `RV_F7_SUB &&
                     w[14:12] == `RV_F3_ADD) begin
            writes = 1'b1;
            result = a - b;
        end
        assert (trs_pc == exp_pc) else report_mismatch("trs_pc", trs_pc, exp_pc);
        assert (trs_instr == w) else report_mismatch("trs_instr", trs_instr, w);
        assert (trs_wen == (writes && rd != 5'd0))
            else report_mismatch("trs_wen", 32'(trs_wen), 32'(writes && rd != 5'd0));
        if (writes) begin
            assert (trs_wdata == result) else report_mismatch("trs_wdata", trs_wdata, result);
            assert (trs_rd == rd) else report_mismatch("trs_rd", 32'(trs_rd), 32'(rd));
        end
        if (writes && rd != 5'd0) ref_regs[rd] = result;
        if (exp_pc == LAST_PC) last_seen <= 1'b1;
        exp_pc   = next_pc;
        retired <= retired + 1;
    endtask

    always @(negedge g_clk) begin
        if (!reset && trs_valid) begin
            check_retire();
        end
    end

    always @(negedge g_clk) begin
        if (dut_i.props_i.any_fired) begin
            abort_run("A protocol assertion on the DUT ports failed");
        end
    end

    // ------------------------------
    // Instruction memory model
    always @(negedge g_clk) begin
        imem_gnt  <= 1'b0;
        imem_recv <= 1'b0;
        if (reset) begin
            mem_busy = 1'b0;
        end else if (mem_busy) begin
            if (recv_wait == 2'd0) begin
                imem_recv  <= 1'b1;                          // Answer the grant
                imem_rdata <= prog_word(gnt_addr);
                mem_busy    = 1'b0;
            end else begin
                recv_wait = recv_wait - 2'd1;
            end
        end else if (imem_req) begin
            if (gnt_wait == 2'd0) begin
                imem_gnt <= 1'b1;
                gnt_addr  = imem_addr;
                mem_busy  = 1'b1;
                draw_delay(recv_wait);
                draw_delay(gnt_wait);                        // For the next request
            end else begin
                gnt_wait = gnt_wait - 2'd1;
            end
        end
    end

    initial begin : main_seq
        int idle;
        int seen;
        reset      = 1'b1;
        imem_gnt   = 1'b0;
        imem_recv  = 1'b0;
        imem_rdata = 32'd0;
        idle       = 0;
        seen       = 0;
        load_program();
        draw_delay(gnt_wait);
        repeat (16) @(posedge g_clk);
        @(negedge g_clk);
        reset <= 1'b0;
        while (!last_seen) begin
            @(negedge g_clk);
            if (retired != seen) begin
                seen = retired;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > IDLE_LIMIT) begin
                abort_run("Timeout while waiting for the next instruction to retire");
            end
        end
        if (dut_i.props_i.any_fired) begin
            abort_run("A protocol assertion on the DUT ports failed");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/rv_pipeline_properties.sv */
// Protocol checks on the instruction memory port and the retire trace.
// Bound into rv_pipeline. any_fired lets the testbench see a failure.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_pipeline_properties (
    input wire                g_clk,
    input wire                reset,
    input wire                imem_req,
    input wire [`RV_XLEN-1:0] imem_addr,
    input wire                imem_gnt,
    input wire                imem_recv,
    input wire                trs_valid
);

    logic outstanding;                   // Granted fetch not yet answered
    logic req_fired    = 1'b0;
    logic single_fired = 1'b0;
    logic recv_fired   = 1'b0;
    logic reset_fired  = 1'b0;
    logic any_fired;

    assign any_fired = req_fired | single_fired | recv_fired | reset_fired;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (imem_req && imem_gnt) begin
            outstanding <= 1'b1;
        end else if (imem_recv) begin
            outstanding <= 1'b0;
        end
    end

    // ------------------------------
    // Port protocol
    req_held: assert property (@(posedge g_clk) disable iff (reset)
        imem_req && !imem_gnt |=> imem_req && $stable(imem_addr))
        else begin
            req_fired = 1'b1;
            $error("imem_req dropped or imem_addr moved before the grant");
        end

    recv_after_gnt: assert property (@(posedge g_clk) disable iff (reset)
        imem_recv |-> outstanding)
        else begin
            recv_fired = 1'b1;
            $error("imem_recv without an outstanding grant");
        end

    // ------------------------------
    // Retire trace
    trs_single: assert property (@(posedge g_clk) disable iff (reset)
        trs_valid |=> !trs_valid)
        else begin
            single_fired = 1'b1;
            $error("trs_valid high in two consecutive cycles");
        end

    trs_quiet_in_reset: assert property (@(posedge g_clk)
        reset |=> !trs_valid)
        else begin
            reset_fired = 1'b1;
            $error("trs_valid high during reset");
        end

endmodule

bind rv_pipeline rv_pipeline_properties props_i (
    .g_clk     (g_clk),
    .reset     (reset),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_gnt  (imem_gnt),
    .imem_recv (imem_recv),
    .trs_valid (trs_valid)
);

`default_nettype wire

/* logic/rv_pipeline.sv */
// Top level of the four-stage RV32I core: fetch, decode, execute and
// writeback. Exposes the instruction memory port and the retire trace.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module rv_pipeline (
    input  wire                   g_clk,
    input  wire                   reset,        // Synchronous, active high
    input  wire                   imem_gnt,
    input  wire                   imem_recv,
    input  wire  [31:0]           imem_rdata,
    output logic                  imem_req,
    output logic [`RV_XLEN-1:0]   imem_addr,
    output logic                  trs_valid,    // Instruction retired
    output logic [`RV_XLEN-1:0]   trs_pc,
    output logic [31:0]           trs_instr,
    output logic                  trs_wen,
    output logic [`RV_REG_AW-1:0] trs_rd,
    output logic [`RV_XLEN-1:0]   trs_wdata
);

    logic [`RV_XLEN-1:0]   pc;
    logic                  step;
    logic                  cf_req;        // JAL redirect
    logic [`RV_XLEN-1:0]   cf_target;
    logic                  s1_valid;      // Fetch to decode
    logic [31:0]           s1_instr;
    logic [`RV_XLEN-1:0]   s1_pc;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_rdata;
    logic [`RV_XLEN-1:0]   rs2_rdata;
    logic                  ex_wen;        // Execute forwarding
    logic [`RV_REG_AW-1:0] ex_rd;
    logic [`RV_XLEN-1:0]   ex_result;

    issue_if iss_bus ();
    wb_if    wb_bus ();

    // ------------------------------
    // Stages
    fetch_ctrl i_fetch (
        .g_clk      (g_clk),     .reset     (reset),
        .imem_gnt   (imem_gnt),  .imem_recv (imem_recv),
        .imem_rdata (imem_rdata),.pc        (pc),
        .cf_req     (cf_req),    .imem_req  (imem_req),
        .imem_addr  (imem_addr), .step      (step),
        .s1_valid   (s1_valid),  .s1_instr  (s1_instr),
        .s1_pc      (s1_pc)
    );

    pc_counter i_pc (
        .g_clk  (g_clk),  .reset     (reset),
        .step   (step),   .cf_req    (cf_req),
        .pc     (pc),     .cf_target (cf_target)
    );

    decode_stage i_decode (
        .g_clk     (g_clk),     .reset     (reset),
        .s1_valid  (s1_valid),  .s1_instr  (s1_instr),
        .s1_pc     (s1_pc),     .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata), .ex_wen    (ex_wen),
        .ex_rd     (ex_rd),     .ex_result (ex_result),
        .wb        (wb_bus),    .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),  .cf_req    (cf_req),
        .cf_target (cf_target), .iss       (iss_bus)
    );

    execute_stage i_execute (
        .g_clk  (g_clk),   .reset     (reset),
        .iss    (iss_bus), .ex_wen    (ex_wen),
        .ex_rd  (ex_rd),   .ex_result (ex_result),
        .wb     (wb_bus)
    );

    gpr_file i_gprs (
        .g_clk     (g_clk),     .reset     (reset),
        .rs1_addr  (rs1_addr),  .rs2_addr  (rs2_addr),
        .wb        (wb_bus),    .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata)
    );

    // ------------------------------
    // Retire trace
    assign trs_valid = wb_bus.valid;
    assign trs_pc    = wb_bus.pc;
    assign trs_instr = wb_bus.instr;
    assign trs_wen   = wb_bus.wen;
    assign trs_rd    = wb_bus.rd;
    assign trs_wdata = wb_bus.wdata;

endmodule

`default_nettype wire

/* logic/gpr_file.sv */
// General purpose registers x1 to x31 with two combinational read
// ports. x0 is not stored and always reads as zero.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module gpr_file (
    input  wire                   g_clk,
    input  wire                   reset,
    input  wire  [`RV_REG_AW-1:0] rs1_addr,
    input  wire  [`RV_REG_AW-1:0] rs2_addr,
    wb_if.sink_mp                 wb,          // Write port
    output logic [`RV_XLEN-1:0]   rs1_rdata,
    output logic [`RV_XLEN-1:0]   rs2_rdata
);

    logic [`RV_XLEN-1:0] regs [1:31];

    // Written at the edge that ends the writeback cycle
    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && wb.rd != '0) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
// Integer ALU and the writeback register. The unregistered result
// also goes back to decode as the first forwarding source.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module execute_stage import rv_pkg::*; (
    input  wire                   g_clk,
    input  wire                   reset,
    issue_if.execute_mp           iss,
    output logic                  ex_wen,      // Forwarding to decode
    output logic [`RV_REG_AW-1:0] ex_rd,
    output logic [`RV_XLEN-1:0]   ex_result,
    wb_if.source_mp               wb
);

    logic [`RV_XLEN-1:0] alu_out;

    always_comb begin
        case (iss.uop)
            UOP_ADD,
            UOP_LINK: alu_out = iss.opr_a + iss.opr_b;
            UOP_SUB:  alu_out = iss.opr_a - iss.opr_b;
            UOP_AND:  alu_out = iss.opr_a & iss.opr_b;
            UOP_OR:   alu_out = iss.opr_a | iss.opr_b;
            UOP_XOR:  alu_out = iss.opr_a ^ iss.opr_b;
            default:  alu_out = '0;              // No result
        endcase
    end

    // Writes only for a real op with rd not x0
    assign ex_wen    = iss.valid && (iss.uop != UOP_NONE) && (iss.rd != '0);
    assign ex_rd     = iss.rd;
    assign ex_result = alu_out;

    // ------------------------------
    // Writeback register
    always_ff @(posedge g_clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
            wb.wen   <= 1'b0;
        end else begin
            wb.valid <= iss.valid;
            wb.wen   <= ex_wen;
        end
    end

    always_ff @(posedge g_clk) begin
        if (iss.valid) begin
            wb.rd    <= iss.rd;
            wb.wdata <= alu_out;
            wb.pc    <= iss.pc;
            wb.instr <= iss.instr;
        end
    end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
// Decode and register read. Selects the micro-op and operands,
// forwards from execute and writeback, raises the JAL redirect and
// loads the issue register feeding execute.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module decode_stage import rv_pkg::*; (
    input  wire                   g_clk,
    input  wire                   reset,
    input  wire                   s1_valid,
    input  wire  [31:0]           s1_instr,
    input  wire  [`RV_XLEN-1:0]   s1_pc,
    input  wire  [`RV_XLEN-1:0]   rs1_rdata,   // Register file
    input  wire  [`RV_XLEN-1:0]   rs2_rdata,
    input  wire                   ex_wen,      // Instruction in execute
    input  wire  [`RV_REG_AW-1:0] ex_rd,
    input  wire  [`RV_XLEN-1:0]   ex_result,
    wb_if.sink_mp                 wb,          // Instruction in writeback
    output logic [`RV_REG_AW-1:0] rs1_addr,
    output logic [`RV_REG_AW-1:0] rs2_addr,
    output logic                  cf_req,
    output logic [`RV_XLEN-1:0]   cf_target,
    issue_if.decode_mp            iss
);

    instr_u              word;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] rs1_fwd;
    logic [`RV_XLEN-1:0] rs2_fwd;
    logic [`RV_XLEN-1:0] opr_a;
    logic [`RV_XLEN-1:0] opr_b;
    uop_e                uop;

    // Youngest producer wins, x0 never forwarded
    function automatic logic [`RV_XLEN-1:0] fwd_sel(
        input logic [`RV_REG_AW-1:0] addr,
        input logic [`RV_XLEN-1:0]   rf_data
    );
        if (addr != '0 && ex_wen && ex_rd == addr) return ex_result;
        if (addr != '0 && wb.wen && wb.rd == addr) return wb.wdata;
        return rf_data;
    endfunction

    // funct3 to ALU op, shared by R and I forms
    function automatic uop_e alu_uop(input logic [2:0] funct3);
        case (funct3)
            `RV_F3_ADD: return UOP_ADD;
            `RV_F3_XOR: return UOP_XOR;
            `RV_F3_OR:  return UOP_OR;
            `RV_F3_AND: return UOP_AND;
            default:    return UOP_NONE;  // Shifts, compares unsupported
        endcase
    endfunction

    assign word     = s1_instr;
    assign rs1_addr = word.r.rs1;
    assign rs2_addr = word.r.rs2;
    assign imm_i    = {{20{word.i.imm[11]}}, word.i.imm};
    assign imm_j    = {{12{s1_instr[31]}}, s1_instr[19:12], s1_instr[20],
                       s1_instr[30:21], 1'b0};

    // Follows the bypass sources as well as the addresses
    always_comb begin
        rs1_fwd = fwd_sel(rs1_addr, rs1_rdata);
        rs2_fwd = fwd_sel(rs2_addr, rs2_rdata);
    end

    assign cf_req    = s1_valid && (word.r.opcode == `RV_OP_JAL);
    assign cf_target = s1_pc + imm_j;

    // ------------------------------
    // Micro-op and operand select
    always_comb begin
        uop   = UOP_NONE;
        opr_a = rs1_fwd;
        opr_b = rs2_fwd;
        case (word.r.opcode)
            `RV_OP_REG: begin
                if (word.r.funct7 == '0) begin
                    uop = alu_uop(word.r.funct3);
                end else if (word.r.funct7 == `RV_F7_SUB &&
                             word.r.funct3 == `RV_F3_ADD) begin
                    uop = UOP_SUB;
                end
            end
            `RV_OP_IMM: begin
                uop   = alu_uop(word.i.funct3);
                opr_b = imm_i;                    // Immediate replaces rs2
            end
            `RV_OP_JAL: begin
                uop   = UOP_LINK;
                opr_a = s1_pc;                    // Link value pc plus 4
                opr_b = `RV_PC_STEP;
            end
            default: uop = UOP_NONE;
        endcase
    end

    // ------------------------------
    // Issue register
    always_ff @(posedge g_clk) begin
        if (reset) begin
            iss.valid <= 1'b0;
        end else begin
            iss.valid <= s1_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s1_valid) begin
            iss.rd    <= word.r.rd;
            iss.uop   <= uop;
            iss.opr_a <= opr_a;
            iss.opr_b <= opr_b;
            iss.pc    <= s1_pc;
            iss.instr <= s1_instr;
        end
    end

endmodule

`default_nettype wire

/* logic/pc_counter.sv */
// Program counter. Steps on each granted sequential fetch and loads
// the jump target from decode, which wins over a step.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module pc_counter (
    input  wire                 g_clk,
    input  wire                 reset,
    input  wire                 step,        // Fetch granted
    input  wire                 cf_req,      // Jump taken in decode
    input  wire [`RV_XLEN-1:0]  cf_target,
    output logic [`RV_XLEN-1:0] pc
);

    always_ff @(posedge g_clk) begin
        if (reset) begin
            pc <= `RV_PC_RESET;
        end else if (cf_req) begin
            pc <= cf_target;                 // Redirect
        end else if (step) begin
            pc <= pc + `RV_PC_STEP;          // Sequential
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_ctrl.sv */
// Fetch FSM on the req/gnt/recv instruction memory port.
// Keeps one fetch outstanding and hands each word to decode as a
// single-cycle s1_valid pulse. Responses made stale by a jump are dropped.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

module fetch_ctrl (
    input  wire                 g_clk,
    input  wire                 reset,
    input  wire                 imem_gnt,     // Request accepted
    input  wire                 imem_recv,    // Response strobe
    input  wire [31:0]          imem_rdata,
    input  wire [`RV_XLEN-1:0]  pc,           // Next sequential address
    input  wire                 cf_req,       // Jump seen in decode
    output logic                imem_req,
    output logic [`RV_XLEN-1:0] imem_addr,
    output logic                step,         // Advance the PC
    output logic                s1_valid,
    output logic [31:0]         s1_instr,
    output logic [`RV_XLEN-1:0] s1_pc
);

    typedef enum logic [1:0] {
        FETCH_REQ,   // Request on the bus
        FETCH_WAIT,  // Granted, response wanted
        FETCH_DROP   // Granted, response thrown away
    } fetch_state_e;

    fetch_state_e        state;
    fetch_state_e        state_nxt;
    logic                stale;    // Pending request predates a jump
    logic [`RV_XLEN-1:0] req_pc;   // Address on the bus, held to delivery

    assign imem_req  = (state == FETCH_REQ);
    assign imem_addr = req_pc;                        // Stable until granted
    assign step      = imem_req && imem_gnt && !stale;

    // ------------------------------
    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            FETCH_REQ: begin
                if (imem_gnt) begin
                    state_nxt = (cf_req || stale) ? FETCH_DROP : FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                if (imem_recv) begin
                    state_nxt = FETCH_REQ;
                end else if (cf_req) begin
                    state_nxt = FETCH_DROP;
                end
            end
            FETCH_DROP: if (imem_recv) state_nxt = FETCH_REQ;  // Swallow it
            default:    state_nxt = FETCH_REQ;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (reset) begin
            state    <= FETCH_REQ;
            stale    <= 1'b0;
            req_pc   <= `RV_PC_RESET;
            s1_valid <= 1'b0;
        end else begin
            state    <= state_nxt;
            s1_valid <= (state == FETCH_WAIT) && imem_recv;
            if (imem_req && imem_gnt) begin
                stale <= 1'b0;
            end else if (imem_req && cf_req) begin
                stale <= 1'b1;                        // Keep addr, drop later
            end
            if (state != FETCH_REQ && imem_recv) begin
                req_pc <= pc;                         // Next request address
            end
        end
    end

    // Word and its address for decode
    always_ff @(posedge g_clk) begin
        if (state == FETCH_WAIT && imem_recv) begin
            s1_instr <= imem_rdata;
            s1_pc    <= req_pc;
        end
    end

endmodule

`default_nettype wire

/* logic/wb_if.sv */
// Retiring result, registered in execute. Feeds the register file,
// the second forwarding path in decode and the trace outputs.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

interface wb_if ();
    logic                  valid;   // Instruction retires this cycle
    logic                  wen;     // Register write, never for x0
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_XLEN-1:0]   pc;
    logic [31:0]           instr;

    modport source_mp (output valid, wen, rd, wdata, pc, instr);
    modport sink_mp   (input  valid, wen, rd, wdata, pc, instr);
endinterface

`default_nettype wire

/* logic/issue_if.sv */
// Decoded instruction leaving the decode issue register for execute.
// One cycle of valid per instruction, no back-pressure.

`timescale 1ns/1ps
`default_nettype none
`include "rv_macros.svh"

interface issue_if import rv_pkg::*; ();
    logic                  valid;   // One cycle per instruction
    logic [`RV_REG_AW-1:0] rd;      // Destination register
    uop_e                  uop;     // Micro-op
    logic [`RV_XLEN-1:0]   opr_a;   // Forwarded operand A
    logic [`RV_XLEN-1:0]   opr_b;   // Operand B or immediate
    logic [`RV_XLEN-1:0]   pc;      // Instruction address
    logic [31:0]           instr;   // Raw word for trace

    modport decode_mp  (output valid, rd, uop, opr_a, opr_b, pc, instr);
    modport execute_mp (input  valid, rd, uop, opr_a, opr_b, pc, instr);
endinterface

`default_nettype wire

/* logic/rv_pkg.sv */
// Types shared across the pipeline: the two views of an instruction
// word and the micro-op set handed from decode to execute.

`default_nettype none

package rv_pkg;

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    // I-type field layout, imm overlays funct7 and rs2
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    typedef enum logic [2:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_LINK,    // rd gets pc plus 4
        UOP_NONE     // Retires with no write
    } uop_e;

endpackage

`default_nettype wire

/* logic/rv_macros.svh */
// Widths, reset vector and RV32I encodings shared by the core.
// Pull in with `include wherever a width or an opcode is needed.

`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN      32              // Data word width
`define RV_REG_AW    5               // Register address width
`define RV_PC_RESET  32'h8000_0000   // First fetch address
`define RV_PC_STEP   32'd4           // Sequential PC increment

`define RV_OP_REG    7'b0110011      // R-type ALU
`define RV_OP_IMM    7'b0010011      // I-type ALU
`define RV_OP_JAL    7'b1101111      // Jump and link

`define RV_F3_ADD    3'b000          // ADD / SUB / ADDI
`define RV_F3_XOR    3'b100
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111
`define RV_F7_SUB    7'b0100000      // funct7 marking SUB

`endif
